/* rtl/soqpsk_defines.svh */
`ifndef SOQPSK_DEFINES_SVH
`define SOQPSK_DEFINES_SVH

// Shaping filter length, four bits at two samples per bit
`define FIR_TAPS 8

// Signed shaping coefficient width
`define COEF_WIDTH 12

// Width of the combiner accumulator
`define SUM_WIDTH 16

// Fraction bits dropped after the deviation multiply
`define DEV_FRAC_BITS 8

`endif

/* rtl/soqpskPkg.sv */
`default_nettype none

`include "soqpsk_defines.svh"

package soqpskPkg;

   typedef logic [31:0] freqWordT;
   typedef logic [17:0] deviationT;
   typedef logic [15:0] bitrateDivT;
   typedef logic [4:0]  gainShiftT;

   // Ternary sample, -1, 0 or +1
   typedef logic signed [1:0] ternaryT;

   typedef logic signed [`COEF_WIDTH-1:0] coefT;
   typedef logic signed [`COEF_WIDTH:0]   tapProdT;
   typedef logic signed [`SUM_WIDTH-1:0]  sumT;

   localparam ternaryT TERN_POS  = 2'sb01;
   localparam ternaryT TERN_NEG  = 2'sb11;
   localparam ternaryT TERN_ZERO = 2'sb00;

   typedef struct packed {
      freqWordT   carrierFreq;
      deviationT  deviation;
      bitrateDivT bitrateDiv;
      gainShiftT  gainShift;
   } modCfgT;

   // Which half of the dibit the precoder is working on
   typedef enum logic {
      phaseI,
      phaseQ
   } bitPhaseT;

   // Half-sine pulse, symmetric about the filter center
   function automatic coefT shapingCoef(input int unsigned idx);
      coefT coef;
      case (idx)
         0, 7:    coef = 12'sd399;
         1, 6:    coef = 12'sd1137;
         2, 5:    coef = 12'sd1702;
         3, 4:    coef = 12'sd2008;
         default: coef = '0;
      endcase
      return coef;
   endfunction

endpackage

`default_nettype wire

/* rtl/soqpskRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module soqpskRegs
   import soqpskPkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        cs,
   input  logic        wr0,
   input  logic        wr1,
   input  logic        wr2,
   input  logic        wr3,
   input  logic [11:0] addr,
   input  logic [31:0] din,
   output logic [31:0] dout,
   output modCfgT      cfg
);

   localparam bitrateDivT BITRATE_DIV_RESET = 16'd15;

   logic [3:0] lanes;

   // Replace only the enabled byte lanes of a word
   function automatic logic [31:0] laneMerge(
      input logic [31:0] old,
      input logic [31:0] data,
      input logic [3:0]  strb
   );
      logic [31:0] merged;
      merged = old;
      for (int i = 0; i < 4; i++) begin
         if (strb[i]) begin
            merged[8*i +: 8] = data[8*i +: 8];
         end
      end
      return merged;
   endfunction

   assign lanes = {wr3, wr2, wr1, wr0};

   always_ff @(posedge clk) begin
      if (reset) begin
         cfg.carrierFreq <= '0;
         cfg.deviation   <= '0;
         cfg.bitrateDiv  <= BITRATE_DIV_RESET;
         cfg.gainShift   <= '0;
      end else if (cs && (lanes != 4'b0000)) begin
         case (addr[3:2])
            2'd0: cfg.carrierFreq <= laneMerge(cfg.carrierFreq, din, lanes);
            2'd1: cfg.deviation <= deviationT'(laneMerge(32'(cfg.deviation), din, lanes));
            2'd2: cfg.bitrateDiv <= bitrateDivT'(laneMerge(32'(cfg.bitrateDiv), din, lanes));
            default: cfg.gainShift <= gainShiftT'(laneMerge(32'(cfg.gainShift), din, lanes));
         endcase
      end
   end

   // Read-back, upper bits of narrow fields are zero
   always_comb begin
      dout = '0;
      if (cs) begin
         case (addr[3:2])
            2'd0:    dout = cfg.carrierFreq;
            2'd1:    dout = 32'(cfg.deviation);
            2'd2:    dout = 32'(cfg.bitrateDiv);
            default: dout = 32'(cfg.gainShift);
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/bitrateTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module bitrateTimer
   import soqpskPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  bitrateDivT bitrateDiv,
   output logic       sampleEn,
   output logic       modClkOut
);

   bitrateDivT count;

   // One strobe every bitrateDiv+1 cycles, bit clock toggles with it
   always_ff @(posedge clk) begin
      if (reset) begin
         count     <= bitrateDiv;
         sampleEn  <= 1'b0;
         modClkOut <= 1'b0;
      end else if (count == '0) begin
         count     <= bitrateDiv;
         sampleEn  <= 1'b1;
         modClkOut <= ~modClkOut;
      end else begin
         count    <= count - 1'b1;
         sampleEn <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* rtl/ternaryPrecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ternaryPrecoder
   import soqpskPkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    sampleEn,
   input  logic    modClkOut,
   input  logic    modData,
   input  logic    modDataValid,
   output ternaryT tapIn,
   output logic    tapShift
);

   bitPhaseT   phase;
   logic       prevOut;
   // Last two precoded bits
   logic [1:0] history;
   logic       dataBit;
   logic       precodedBit;
   logic [2:0] nextHistory;
   ternaryT    symbol;

   // Invalid data is taken as a zero bit
   assign dataBit = modDataValid & modData;

   // IRIG precoding
   // I bits use the inverted previous output and Q bits use it directly
   always_comb begin
      if (phase == phaseI) begin
         precodedBit = dataBit ^ ~prevOut;
      end else begin
         precodedBit = dataBit ^ prevOut;
      end
   end

   assign nextHistory = {history, precodedBit};

   // Dibit to ternary mapping with the sign set by the current phase
   always_comb begin
      case (nextHistory)
         3'b001, 3'b110: begin
            symbol = (phase == phaseI) ? TERN_POS : TERN_NEG;
         end
         3'b011, 3'b100: begin
            symbol = (phase == phaseI) ? TERN_NEG : TERN_POS;
         end
         default: begin
            symbol = TERN_ZERO;
         end
      endcase
   end

   // Bit state only advances on the high half of the bit clock
   always_ff @(posedge clk) begin
      if (reset) begin
         phase   <= phaseI;
         prevOut <= 1'b0;
         history <= 2'b00;
      end else if (sampleEn && modClkOut) begin
         prevOut <= precodedBit;
         history <= nextHistory[1:0];
         phase   <= (phase == phaseI) ? phaseQ : phaseI;
      end
   end

   // Two samples per bit
   // Symbol on the high half and zero on the low half
   always_ff @(posedge clk) begin
      if (reset) begin
         tapIn    <= TERN_ZERO;
         tapShift <= 1'b0;
      end else begin
         tapShift <= sampleEn;
         if (sampleEn) begin
            tapIn <= modClkOut ? symbol : TERN_ZERO;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/firTap.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soqpsk_defines.svh"

module firTap
   import soqpskPkg::*;
#(
   parameter coefT coef = '0
) (
   input  logic    clk,
   input  logic    reset,
   input  logic    shift,
   input  ternaryT sampleIn,
   output ternaryT sampleOut,
   output tapProdT product
);

   localparam tapProdT COEF_EXT = {coef[`COEF_WIDTH-1], coef};

   // Ternary input makes the multiply a select
   always_ff @(posedge clk) begin
      if (reset) begin
         sampleOut <= TERN_ZERO;
         product   <= '0;
      end else if (shift) begin
         sampleOut <= sampleIn;
         case (sampleIn)
            TERN_POS: product <= COEF_EXT;
            TERN_NEG: product <= -COEF_EXT;
            default:  product <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/shapingCombiner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soqpsk_defines.svh"

module shapingCombiner
   import soqpskPkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  tapProdT  products [`FIR_TAPS],
   input  modCfgT   cfg,
   output freqWordT soqpskModFreq
);

   localparam int PROD_WIDTH = `SUM_WIDTH + $bits(deviationT) + 1;

   sumT                          sumNext;
   sumT                          sumReg;
   sumT                          shifted;
   logic signed [PROD_WIDTH-1:0] devProd;
   freqWordT                     scaledReg;

   // Adder tree over all tap products
   always_comb begin
      sumNext = '0;
      for (int k = 0; k < `FIR_TAPS; k++) begin
         sumNext = sumNext + sumT'(products[k]);
      end
   end

   // Gain shift then deviation scaling, deviation treated as unsigned
   assign shifted = sumReg >>> cfg.gainShift;
   assign devProd = shifted * $signed({1'b0, cfg.deviation});

   always_ff @(posedge clk) begin
      if (reset) begin
         sumReg        <= '0;
         scaledReg     <= '0;
         soqpskModFreq <= '0;
      end else begin
         sumReg        <= sumNext;
         scaledReg     <= freqWordT'(devProd >>> `DEV_FRAC_BITS);
         // Carrier add wraps modulo 2^32
         soqpskModFreq <= cfg.carrierFreq + scaledReg;
      end
   end

endmodule

`default_nettype wire

/* rtl/soqpskModulator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soqpsk_defines.svh"

module soqpskModulator
   import soqpskPkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        cs,
   input  logic        wr0,
   input  logic        wr1,
   input  logic        wr2,
   input  logic        wr3,
   input  logic [11:0] addr,
   input  logic [31:0] din,
   output logic [31:0] dout,
   input  logic        modData,
   input  logic        modDataValid,
   output logic        modClkOut,
   output logic        modSampleEn,
   output freqWordT    soqpskModFreq
);

   modCfgT  cfg;
   ternaryT tapIn;
   logic    tapShift;
   ternaryT tapSamples [`FIR_TAPS];
   tapProdT tapProducts [`FIR_TAPS];

   soqpskRegs u_regs (
      .clk   (clk),
      .reset (reset),
      .cs    (cs),
      .wr0   (wr0),
      .wr1   (wr1),
      .wr2   (wr2),
      .wr3   (wr3),
      .addr  (addr),
      .din   (din),
      .dout  (dout),
      .cfg   (cfg)
   );

   bitrateTimer u_timer (
      .clk        (clk),
      .reset      (reset),
      .bitrateDiv (cfg.bitrateDiv),
      .sampleEn   (modSampleEn),
      .modClkOut  (modClkOut)
   );

   ternaryPrecoder u_precoder (
      .clk          (clk),
      .reset        (reset),
      .sampleEn     (modSampleEn),
      .modClkOut    (modClkOut),
      .modData      (modData),
      .modDataValid (modDataValid),
      .tapIn        (tapIn),
      .tapShift     (tapShift)
   );

   // Shaping filter delay line, tap 0 is fed by the precoder
   for (genvar k = 0; k < `FIR_TAPS; k++) begin : gTap
      firTap #(
         .coef (shapingCoef(k))
      ) u_tap (
         .clk       (clk),
         .reset     (reset),
         .shift     (tapShift),
         .sampleIn  ((k == 0) ? tapIn : tapSamples[(k == 0) ? 0 : k - 1]),
         .sampleOut (tapSamples[k]),
         .product   (tapProducts[k])
      );
   end

   shapingCombiner u_combiner (
      .clk           (clk),
      .reset         (reset),
      .products      (tapProducts),
      .cfg           (cfg),
      .soqpskModFreq (soqpskModFreq)
   );

endmodule

`default_nettype wire

/* sim/soqpskModulatorTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soqpsk_defines.svh"

module soqpskModulatorTb
   import soqpskPkg::*;
();

   localparam int RUN_DIV = 9;
   localparam int BIT_CYCLES = 2 * (RUN_DIV + 1);

   // Cycle budget of each test
   localparam int RESET_BUDGET = 16;
   localparam int REG_BUDGET = 600;
   localparam int TIMER_BUDGET = 500;
   localparam int CARRIER_BUDGET = 16 * BIT_CYCLES + 200;
   localparam int CONST_BUDGET = 48 * BIT_CYCLES + 200;
   localparam int RANDOM_BUDGET = 128 * BIT_CYCLES + 400;
   localparam int INVALID_BUDGET = 24 * BIT_CYCLES + 200;
   localparam int TEST_CYCLES = RESET_BUDGET + REG_BUDGET + TIMER_BUDGET + CARRIER_BUDGET
                                + CONST_BUDGET + RANDOM_BUDGET + INVALID_BUDGET;
   // Watchdog allows twice the total
   localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

   localparam int MODE_ONES = 0;
   localparam int MODE_ZEROS = 1;
   localparam int MODE_RANDOM = 2;
   localparam int MODE_INVALID = 3;

   logic        clk;
   logic        reset;
   logic        cs;
   logic        wr0;
   logic        wr1;
   logic        wr2;
   logic        wr3;
   logic [11:0] addr;
   logic [31:0] din;
   logic [31:0] dout;
   logic        modData;
   logic        modDataValid;
   logic        modClkOut;
   logic        modSampleEn;
   freqWordT    soqpskModFreq;

   int          errorCount;
   int          checkCount;
   int          cycleCount;
   logic        checkEnable;
   logic        carrierWatch;
   logic [31:0] rngState;

   // Expected register contents
   logic [31:0] shadowCarrier;
   logic [31:0] shadowDev;
   logic [31:0] shadowDiv;
   logic [31:0] shadowGain;

   // Reference precoder and delay line state
   logic        modelClk;
   logic        modelPhaseQ;
   logic        modelPrev;
   logic [2:0]  modelHist;
   int          modelTaps [`FIR_TAPS];

   soqpskModulator u_soqpskModulator (
      .clk           (clk),
      .reset         (reset),
      .cs            (cs),
      .wr0           (wr0),
      .wr1           (wr1),
      .wr2           (wr2),
      .wr3           (wr3),
      .addr          (addr),
      .din           (din),
      .dout          (dout),
      .modData       (modData),
      .modDataValid  (modDataValid),
      .modClkOut     (modClkOut),
      .modSampleEn   (modSampleEn),
      .soqpskModFreq (soqpskModFreq)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         $display("Run stopped at %0t after %0d cycles without finishing", $time, cycleCount);
         $display("tests failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] mergeLanes(
      input logic [31:0] old,
      input logic [31:0] data,
      input logic [3:0]  lanes,
      input logic [31:0] mask
   );
      logic [31:0] word;
      word = old;
      for (int i = 0; i < 4; i++) begin
         if (lanes[i]) begin
            word[8*i +: 8] = data[8*i +: 8];
         end
      end
      return word & mask;
   endfunction

   // Filter sum, gain shift, deviation scaling and carrier add
   function automatic logic [31:0] expectedFreq();
      longint acc;
      longint scaled;
      logic [31:0] low;
      acc = 0;
      for (int k = 0; k < `FIR_TAPS; k++) begin
         acc = acc + longint'(modelTaps[k]) * longint'(shapingCoef(k));
      end
      acc = acc >>> shadowGain[4:0];
      scaled = (acc * longint'(shadowDev)) >>> `DEV_FRAC_BITS;
      low = scaled[31:0];
      return shadowCarrier + low;
   endfunction

   // Reference model stepped once per half-bit strobe
   always @(negedge clk) begin : modelStep
      logic    bitIn;
      logic    pre;
      logic [2:0] hist;
      int      sym;
      logic [31:0] want;
      if (reset) begin
         modelClk = 1'b0;
         modelPhaseQ = 1'b0;
         modelPrev = 1'b0;
         modelHist = 3'b000;
         for (int k = 0; k < `FIR_TAPS; k++) begin
            modelTaps[k] = 0;
         end
         shadowCarrier = 32'd0;
         shadowDev = 32'd0;
         shadowDiv = 32'd15;
         shadowGain = 32'd0;
      end else begin
         if (carrierWatch) begin
            checkCount++;
            if (soqpskModFreq !== shadowCarrier) begin
               errorCount++;
               $display("Mismatch at %0t: frequency %h with zero deviation, carrier %h",
                        $time, soqpskModFreq, shadowCarrier);
            end
         end
         if (modSampleEn) begin
            if (checkEnable) begin
               want = expectedFreq();
               checkCount++;
               if (soqpskModFreq !== want) begin
                  errorCount++;
                  $display("Mismatch at %0t: frequency %h, expected %h",
                           $time, soqpskModFreq, want);
               end
            end
            modelClk = ~modelClk;
            if (modClkOut !== modelClk) begin
               errorCount++;
               $display("Mismatch at %0t: bit clock %b, expected %b", $time, modClkOut, modelClk);
            end
            sym = 0;
            if (modelClk) begin
               bitIn = modDataValid & modData;
               pre = modelPhaseQ ? (bitIn ^ modelPrev) : (bitIn ^ ~modelPrev);
               hist = {modelHist[1:0], pre};
               if (hist == 3'b001 || hist == 3'b110) begin
                  sym = modelPhaseQ ? -1 : 1;
               end else if (hist == 3'b011 || hist == 3'b100) begin
                  sym = modelPhaseQ ? 1 : -1;
               end
               modelHist = hist;
               modelPrev = pre;
               modelPhaseQ = ~modelPhaseQ;
            end
            for (int k = `FIR_TAPS - 1; k > 0; k--) begin
               modelTaps[k] = modelTaps[k-1];
            end
            modelTaps[0] = sym;
         end
      end
   end

   task automatic regWrite(input logic [11:0] a, input logic [31:0] data, input logic [3:0] lanes);
      @(negedge clk);
      cs = 1'b1;
      addr = a;
      din = data;
      {wr3, wr2, wr1, wr0} = lanes;
      case (a[3:2])
         2'd0: shadowCarrier = mergeLanes(shadowCarrier, data, lanes, 32'hFFFF_FFFF);
         2'd1: shadowDev = mergeLanes(shadowDev, data, lanes, 32'h0003_FFFF);
         2'd2: shadowDiv = mergeLanes(shadowDiv, data, lanes, 32'h0000_FFFF);
         default: shadowGain = mergeLanes(shadowGain, data, lanes, 32'h0000_001F);
      endcase
      @(negedge clk);
      cs = 1'b0;
      {wr3, wr2, wr1, wr0} = 4'b0000;
   endtask

   task automatic readCheck(input logic [11:0] a, input logic [31:0] expected);
      @(negedge clk);
      cs = 1'b1;
      addr = a;
      @(negedge clk);
      checkCount++;
      if (dout !== expected) begin
         errorCount++;
         $display("Mismatch at %0t: read %h at address %h, expected %h", $time, dout, a, expected);
      end
      cs = 1'b0;
   endtask

   // Counts falling edges up to and including the next strobe
   task automatic nextStrobe(output int cycles);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!modSampleEn);
   endtask

   task automatic waitHalf(input logic level);
      do begin
         @(negedge clk);
      end while (!(modSampleEn && modClkOut == level));
   endtask

   task automatic setChecks(input logic on);
      @(negedge clk);
      checkEnable = on;
   endtask

   task automatic setConfig(input logic [31:0] carrier, input logic [31:0] dev,
                            input logic [31:0] gain);
      int unused;
      setChecks(1'b0);
      regWrite(12'h000, carrier, 4'b1111);
      regWrite(12'h004, dev, 4'b1111);
      regWrite(12'h00C, gain, 4'b1111);
      nextStrobe(unused);
      nextStrobe(unused);
      setChecks(1'b1);
   endtask

   // New bit goes out after each low half, ahead of the next high-half strobe
   task automatic runBits(input int count, input int mode);
      waitHalf(1'b0);
      for (int i = 0; i < count; i++) begin
         @(negedge clk);
         rngState = xorshift32(rngState);
         case (mode)
            MODE_ONES: begin
               modData = 1'b1;
               modDataValid = 1'b1;
            end
            MODE_ZEROS: begin
               modData = 1'b0;
               modDataValid = 1'b1;
            end
            MODE_RANDOM: begin
               modData = rngState[0];
               modDataValid = 1'b1;
            end
            default: begin
               modData = rngState[0];
               modDataValid = 1'b0;
            end
         endcase
         waitHalf(1'b1);
         waitHalf(1'b0);
      end
   endtask

   task automatic registerReadback();
      readCheck(12'h000, 32'h0000_0000);
      readCheck(12'h004, 32'h0000_0000);
      readCheck(12'h008, 32'h0000_000F);
      readCheck(12'h00C, 32'h0000_0000);
      regWrite(12'h000, 32'h1234_5678, 4'b1111);
      readCheck(12'h000, 32'h1234_5678);
      regWrite(12'h000, 32'hAABB_CCDD, 4'b0010);
      readCheck(12'h000, 32'h1234_CC78);
      regWrite(12'h000, 32'h9900_0011, 4'b1001);
      readCheck(12'h000, 32'h9934_CC11);
      regWrite(12'h004, 32'hFFFF_FFFF, 4'b1111);
      readCheck(12'h004, 32'h0003_FFFF);
      regWrite(12'h004, 32'h0000_0000, 4'b0100);
      readCheck(12'h004, 32'h0000_FFFF);
      regWrite(12'h004, 32'h0000_005A, 4'b0001);
      readCheck(12'h004, 32'h0000_FF5A);
      regWrite(12'h008, 32'hABCD_0009, 4'b1111);
      readCheck(12'h008, 32'h0000_0009);
      regWrite(12'h008, 32'h0000_0100, 4'b0010);
      readCheck(12'h008, 32'h0000_0109);
      regWrite(12'h008, 32'h0000_0000, 4'b0010);
      readCheck(12'h008, 32'h0000_0009);
      regWrite(12'h00C, 32'hFFFF_FFFF, 4'b1111);
      readCheck(12'h00C, 32'h0000_001F);
      regWrite(12'h00C, 32'hFFFF_FF00, 4'b0010);
      readCheck(12'h00C, 32'h0000_001F);
      regWrite(12'h00C, 32'h0000_0002, 4'b0001);
      readCheck(12'h00C, 32'h0000_0002);
      // Strobes without chip select must be ignored
      @(negedge clk);
      addr = 12'h000;
      din = 32'hDEAD_BEEF;
      {wr3, wr2, wr1, wr0} = 4'b1111;
      @(negedge clk);
      {wr3, wr2, wr1, wr0} = 4'b0000;
      checkCount++;
      if (dout !== 32'h0000_0000) begin
         errorCount++;
         $display("Mismatch at %0t: read %h with chip select low", $time, dout);
      end
      readCheck(12'h000, 32'h9934_CC11);
   endtask

   task automatic measureTimer(input int div);
      int   cycles;
      logic lastLevel;
      regWrite(12'h008, 32'(div), 4'b0011);
      nextStrobe(cycles);
      nextStrobe(cycles);
      lastLevel = modClkOut;
      repeat (4) begin
         nextStrobe(cycles);
         checkCount++;
         if (cycles != shadowDiv + 1) begin
            errorCount++;
            $display("Mismatch at %0t: strobe period %0d, expected %0d",
                     $time, cycles, shadowDiv + 1);
         end
         if (modClkOut !== ~lastLevel) begin
            errorCount++;
            $display("Mismatch at %0t: bit clock %b did not toggle", $time, modClkOut);
         end
         lastLevel = modClkOut;
      end
   endtask

   task automatic timerPeriods();
      int unused;
      measureTimer(7);
      measureTimer(12);
      regWrite(12'h008, 32'(RUN_DIV), 4'b0011);
      nextStrobe(unused);
      nextStrobe(unused);
   endtask

   task automatic carrierOnly();
      setConfig(32'h2468_ACE0, 32'd0, 32'd3);
      @(negedge clk);
      carrierWatch = 1'b1;
      runBits(16, MODE_RANDOM);
      @(negedge clk);
      carrierWatch = 1'b0;
   endtask

   task automatic constantPatterns();
      setConfig(32'h4000_0000, 32'h0000_0C00, 32'd2);
      runBits(24, MODE_ONES);
      runBits(24, MODE_ZEROS);
   endtask

   task automatic randomBits();
      setConfig(32'h1000_0000, 32'h0000_1000, 32'd1);
      runBits(64, MODE_RANDOM);
      // Small carrier so negative deviation wraps
      setConfig(32'h0000_0010, 32'h0002_ABCD, 32'd4);
      runBits(64, MODE_RANDOM);
   endtask

   task automatic invalidBits();
      setConfig(32'h8000_0000, 32'h0000_0800, 32'd0);
      runBits(24, MODE_INVALID);
      setChecks(1'b0);
   endtask

   initial begin
      reset = 1'b1;
      cs = 1'b0;
      wr0 = 1'b0;
      wr1 = 1'b0;
      wr2 = 1'b0;
      wr3 = 1'b0;
      addr = 12'h000;
      din = 32'h0000_0000;
      modData = 1'b0;
      modDataValid = 1'b0;
      errorCount = 0;
      checkCount = 0;
      cycleCount = 0;
      checkEnable = 1'b0;
      carrierWatch = 1'b0;
      rngState = 32'd22422;
      repeat (16) @(negedge clk);
      reset = 1'b0;

      registerReadback();
      timerPeriods();
      carrierOnly();
      constantPatterns();
      randomBits();
      invalidBits();

      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
+incdir+rtl
rtl/soqpskPkg.sv
rtl/soqpskRegs.sv
rtl/bitrateTimer.sv
rtl/ternaryPrecoder.sv
rtl/firTap.sv
rtl/shapingCombiner.sv
rtl/soqpskModulator.sv
sim/soqpskModulatorTb.sv
